/* hw/rom_parity_cfg.svh */
// size settings for the parity ROM, included by the RTL, the package and the testbench
`ifndef ROM_PARITY_CFG_SVH
`define ROM_PARITY_CFG_SVH

// number of interleaved banks
// selected by word address bits 1:0
`define ROM_BANKS 4

// words held by one bank
`define ROM_DEPTH 64

// stored word width
// 11 data bits with the even-parity bit as MSB
`define ROM_BITS 12

// response FIFO entries
// this is also the limit on reads in flight
`define RESP_DEPTH 8

`endif

/* hw/rom_parity_pkg.sv */
// shared types, AXI response codes and the ROM contents formula for the parity ROM
`include "rom_parity_cfg.svh"

package rom_parity_pkg;

    localparam int ROM_DW = `ROM_BITS - 1;

    typedef logic [$clog2(`ROM_BANKS)-1:0] bank_idx_t;
    typedef logic [$clog2(`ROM_DEPTH)-1:0] word_idx_t;
    typedef logic [ROM_DW-1:0]             rom_data_t;
    typedef logic [1:0]                    axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;
    localparam axi_resp_t RESP_DECERR = 2'b11;

    // odd multiply, xor-shift and constant xor are all bijective
    // so no two words come out the same
    function automatic rom_data_t rom_word(input bank_idx_t bank, input word_idx_t idx);
        rom_data_t mix;
        mix = rom_data_t'({idx, bank});
        mix = rom_data_t'(mix * rom_data_t'(1237));
        mix = mix ^ (mix >> 5);
        return mix ^ rom_data_t'(11'h2a5);
    endfunction

endpackage

/* hw/rom_parity.sv */
// one read-only bank with a three-stage address, read and parity pipeline
`timescale 1ns/1ps
`include "rom_parity_cfg.svh"

module rom_parity
    import rom_parity_pkg::*;
#(
    parameter int unsigned BANK_ID = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  word_idx_t            addr,
    output logic                 resp_valid,
    output logic [`ROM_BITS-1:0] data
);

    localparam int DW = ROM_DW;

    rom_data_t mem [`ROM_DEPTH];

    // contents come from the package formula for this bank
    initial begin
        for (int i = 0; i < `ROM_DEPTH; i++) begin
            mem[i] = rom_word(bank_idx_t'(BANK_ID), word_idx_t'(i));
        end
    end

    // stage 1 address register
    logic      s1_valid;
    word_idx_t s1_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= addr;
    end

    // stage 2 array read
    logic      s2_valid;
    rom_data_t s2_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_data <= mem[s1_addr];
        end
    end

    // four partial xors feed one final xor
    logic [3:0] blk_par;
    logic       parity;

    assign blk_par[0] = ^s2_data[DW/4-1:0];
    assign blk_par[1] = ^s2_data[DW/2-1:DW/4];
    assign blk_par[2] = ^s2_data[3*DW/4-1:DW/2];
    assign blk_par[3] = ^s2_data[DW-1:3*DW/4];
    assign parity     = ^blk_par;

    // stage 3 parity goes above the data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            data <= {parity, s2_data};
        end
    end

    // three cycles later the whole word carries even parity
    a_resp_latency: assert property (
        @(posedge clk) disable iff (!rst_n) req_valid |-> ##3 (resp_valid && !(^data))
    );

endmodule

/* hw/axil_read_dispatch.sv */
// AXI4-Lite front end that steers reads to banks, tracks read credit and rejects writes
`timescale 1ns/1ps
`include "rom_parity_cfg.svh"

module axil_read_dispatch
    import rom_parity_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // read address channel
    input  logic [31:0]           araddr,
    input  logic                  arvalid,
    output logic                  arready,
    // write address, data and response channels
    input  logic [31:0]           awaddr,
    input  logic                  awvalid,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  awready,
    output logic                  wready,
    output axi_resp_t             bresp,
    output logic                  bvalid,
    input  logic                  bready,
    // bank requests
    output logic [`ROM_BANKS-1:0] req_valid,
    output word_idx_t             req_addr,
    // tags for the collector
    output logic                  tag_valid,
    output bank_idx_t             tag_bank,
    output logic                  tag_decerr,
    input  logic                  pop
);

    localparam int BANK_W = $bits(bank_idx_t);
    localparam int IDX_W  = $bits(word_idx_t);
    localparam int TOP_LO = 2 + BANK_W + IDX_W;
    localparam int CNT_W  = $clog2(`RESP_DEPTH + 1);

    logic             ar_fire;
    logic             ar_in_range;
    bank_idx_t        ar_bank;
    word_idx_t        ar_idx;
    logic [CNT_W-1:0] outstanding;

    // byte address bits 3:2 pick the bank and 9:4 the word in it
    assign ar_bank     = araddr[2 +: BANK_W];
    assign ar_idx      = araddr[2 + BANK_W +: IDX_W];
    assign ar_in_range = (araddr[31:TOP_LO] == '0);

    // stall AR once every response slot is spoken for
    assign arready = (outstanding != CNT_W'(`RESP_DEPTH));
    assign ar_fire = arvalid && arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= '0;
            tag_valid <= 1'b0;
        end else begin
            req_valid <= '0;
            if (ar_fire && ar_in_range) begin
                req_valid[ar_bank] <= 1'b1;
            end
            tag_valid <= ar_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            req_addr   <= ar_idx;
            tag_bank   <= ar_bank;
            tag_decerr <= !ar_in_range;
        end
    end

    // reads accepted and not yet returned on R
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            case ({ar_fire, pop})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // the ROM is read only
    // AW and W are taken together and dropped
    logic wr_fire;

    assign awready = !bvalid && awvalid && wvalid;
    assign wready  = awready;
    assign wr_fire = awready;
    assign bresp   = RESP_SLVERR;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n) outstanding <= CNT_W'(`RESP_DEPTH)
    );

endmodule

/* hw/resp_collector.sv */
// gathers bank results in request order and drives the AXI4-Lite R channel
`timescale 1ns/1ps
`include "rom_parity_cfg.svh"

module resp_collector
    import rom_parity_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    // tags from the dispatcher
    input  logic                                 tag_valid,
    input  bank_idx_t                            tag_bank,
    input  logic                                 tag_decerr,
    // bank outputs
    input  logic [`ROM_BANKS-1:0]                bank_valid,
    input  logic [`ROM_BANKS-1:0][`ROM_BITS-1:0] bank_data,
    // read data channel
    output logic [31:0]                          rdata,
    output axi_resp_t                            rresp,
    output logic                                 rvalid,
    input  logic                                 rready,
    output logic                                 pop
);

    localparam int LAT   = 3;
    localparam int PTR_W = $clog2(`RESP_DEPTH);
    localparam int CNT_W = $clog2(`RESP_DEPTH + 1);

    // tag pipe matches the bank latency
    logic [LAT-1:0] tv_pipe;
    logic [LAT-1:0] td_pipe;
    bank_idx_t      tb_pipe [LAT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tv_pipe <= '0;
        end else begin
            tv_pipe <= {tv_pipe[LAT-2:0], tag_valid};
        end
    end

    always_ff @(posedge clk) begin
        td_pipe    <= {td_pipe[LAT-2:0], tag_decerr};
        tb_pipe[0] <= tag_bank;
        for (int i = 1; i < LAT; i++) begin
            tb_pipe[i] <= tb_pipe[i-1];
        end
    end

    logic                 push;
    logic                 dly_decerr;
    bank_idx_t            dly_bank;
    logic [`ROM_BITS-1:0] sel_data;
    axi_resp_t            sel_resp;

    assign push       = tv_pipe[LAT-1];
    assign dly_decerr = td_pipe[LAT-1];
    assign dly_bank   = tb_pipe[LAT-1];

    // out of range reads return zero
    assign sel_data = dly_decerr ? '0 : bank_data[dly_bank];
    assign sel_resp = dly_decerr ? RESP_DECERR : RESP_OKAY;

    // response FIFO, entries hold {resp, data}
    logic [`ROM_BITS+1:0] fifo_mem [`RESP_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= {sel_resp, sel_data};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head of the FIFO drives R
    assign rvalid = (count != '0);
    assign pop    = rvalid && rready;
    assign rresp  = fifo_mem[rd_ptr][`ROM_BITS +: 2];
    assign rdata  = {{(32 - `ROM_BITS){1'b0}}, fifo_mem[rd_ptr][`ROM_BITS-1:0]};

    a_tag_meets_bank: assert property (
        @(posedge clk) disable iff (!rst_n)
        (push && !dly_decerr) |-> bank_valid[dly_bank]
    );

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (count != CNT_W'(`RESP_DEPTH)) || pop
    );

endmodule

/* hw/parity_rom_top.sv */
// top level of the parity ROM with its AXI4-Lite slave port
`timescale 1ns/1ps
`include "rom_parity_cfg.svh"

module parity_rom_top
    import rom_parity_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output axi_resp_t   rresp,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output axi_resp_t   bresp,
    output logic        bvalid,
    input  logic        bready
);

    logic [`ROM_BANKS-1:0]                req_valid;
    word_idx_t                            req_addr;
    logic                                 tag_valid;
    bank_idx_t                            tag_bank;
    logic                                 tag_decerr;
    logic [`ROM_BANKS-1:0]                bank_valid;
    logic [`ROM_BANKS-1:0][`ROM_BITS-1:0] bank_data;
    logic                                 pop;

    axil_read_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .awready    (awready),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .tag_valid  (tag_valid),
        .tag_bank   (tag_bank),
        .tag_decerr (tag_decerr),
        .pop        (pop)
    );

    // address is shared, only the selected bank sees req_valid
    for (genvar g = 0; g < `ROM_BANKS; g++) begin : g_bank
        rom_parity #(
            .BANK_ID (g)
        ) u_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .req_valid  (req_valid[g]),
            .addr       (req_addr),
            .resp_valid (bank_valid[g]),
            .data       (bank_data[g])
        );
    end

    resp_collector u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .tag_valid  (tag_valid),
        .tag_bank   (tag_bank),
        .tag_decerr (tag_decerr),
        .bank_valid (bank_valid),
        .bank_data  (bank_data),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .pop        (pop)
    );

endmodule

/* verif/rom_checker.sv */
// scoreboard that watches the AXI4-Lite port of the parity ROM and checks every response
`timescale 1ns/1ps
`include "rom_parity_cfg.svh"

module rom_checker
    import rom_parity_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  axi_resp_t   rresp,
    input  logic        rvalid,
    input  logic        rready,
    input  logic        awvalid,
    input  logic        awready,
    input  logic        wvalid,
    input  logic        wready,
    input  axi_resp_t   bresp,
    input  logic        bvalid,
    input  logic        bready,
    output int          mismatches,
    output int          open_count
);

    string       cur_name = "none";
    axi_resp_t   cur_resp = RESP_OKAY;
    logic [31:0] rd_addr [$];
    string       rd_name [$];
    axi_resp_t   rd_resp [$];
    string       wr_name [$];
    axi_resp_t   wr_resp [$];
    logic [31:0] ck_addr;
    logic [31:0] ck_data;
    axi_resp_t   ck_resp;
    string       ck_name;

    // called by the testbench before each table entry
    task automatic note_entry(input string name, input axi_resp_t resp);
        cur_name = name;
        cur_resp = resp;
    endtask

    // formula data with its even-parity bit on top
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        rom_data_t d;
        d = rom_word(bank_idx_t'(addr[3:2]), word_idx_t'(addr[9:4]));
        return 32'({^d, d});
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            mismatches = 0;
        end else begin
            if (arvalid && arready) begin
                rd_addr.push_back(araddr);
                rd_name.push_back(cur_name);
                rd_resp.push_back(cur_resp);
            end
            if (rvalid && rready) begin
                if (rd_addr.size() == 0) begin
                    $display("[ERROR] read response arrived with no read outstanding");
                    mismatches++;
                end else begin
                    ck_addr = rd_addr.pop_front();
                    ck_name = rd_name.pop_front();
                    ck_resp = rd_resp.pop_front();
                    // DECERR carries zero data
                    ck_data = (ck_resp == RESP_OKAY) ? expected_word(ck_addr) : 32'd0;
                    if (rdata !== ck_data || rresp !== ck_resp) begin
                        $display("[ERROR] %s addr %h expected %h resp %0d actual %h resp %0d",
                                 ck_name, ck_addr, ck_data, ck_resp, rdata, rresp);
                        mismatches++;
                    end
                end
            end
            if (awvalid && awready && wvalid && wready) begin
                wr_name.push_back(cur_name);
                wr_resp.push_back(cur_resp);
            end
            if (bvalid && bready) begin
                if (wr_name.size() == 0) begin
                    $display("[ERROR] write response arrived with no write outstanding");
                    mismatches++;
                end else begin
                    ck_name = wr_name.pop_front();
                    ck_resp = wr_resp.pop_front();
                    if (bresp !== ck_resp) begin
                        $display("[ERROR] %s bresp expected %0d actual %0d",
                                 ck_name, ck_resp, bresp);
                        mismatches++;
                    end
                end
            end
        end
        open_count = rd_addr.size() + wr_name.size();
    end

endmodule

/* verif/tb_parity_rom.sv */
// testbench for the parity ROM, runs a table of AXI4-Lite reads and writes against the DUT
`timescale 1ns/1ps
`include "rom_parity_cfg.svh"

module tb_parity_rom;
    import rom_parity_pkg::*;

    localparam int OP_READ      = 0;
    localparam int OP_WRITE     = 1;
    localparam int RR_ALWAYS    = 0;
    localparam int RR_RANDOM    = 1;
    localparam int RR_STALL     = 2;
    localparam int STALL_CYCLES = 20;
    localparam int MAX_ENTRIES  = 64;

    logic        clk;
    logic        rst_n;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    axi_resp_t   rresp;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    axi_resp_t   bresp;
    logic        bvalid;
    logic        bready;
    int          mismatches;
    int          open_count;

    // stimulus table
    string       t_name [MAX_ENTRIES];
    int          t_op   [MAX_ENTRIES];
    logic [31:0] t_addr [MAX_ENTRIES];
    int          t_rr   [MAX_ENTRIES];
    axi_resp_t   t_resp [MAX_ENTRIES];
    int          n_entries = 0;

    int    cycles      = 0;
    int    cycle_limit = 0;
    int    stall_left  = 0;
    int    rr_mode     = RR_ALWAYS;
    int    tb_errors   = 0;
    string cur_name    = "reset";

    parity_rom_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

    rom_checker chk0 (
        .clk(clk), .rst_n(rst_n),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .mismatches(mismatches), .open_count(open_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles while running %s", cycles, cur_name);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic add_entry(input string name, input int op, input logic [31:0] addr,
                             input int rr, input axi_resp_t resp);
        t_name[n_entries] = name;
        t_op[n_entries]   = op;
        t_addr[n_entries] = addr;
        t_rr[n_entries]   = rr;
        t_resp[n_entries] = resp;
        n_entries++;
    endtask

    task automatic build_table();
        add_entry("single_b0", OP_READ, 32'h000, RR_ALWAYS, RESP_OKAY);
        add_entry("single_b1", OP_READ, 32'h004, RR_ALWAYS, RESP_OKAY);
        add_entry("single_b2", OP_READ, 32'h008, RR_ALWAYS, RESP_OKAY);
        add_entry("single_b3", OP_READ, 32'h3fc, RR_ALWAYS, RESP_OKAY);
        for (int i = 0; i < 8; i++) begin
            add_entry("back_to_back", OP_READ, 32'h040 + 4 * i, RR_ALWAYS, RESP_OKAY);
        end
        // two more than the FIFO holds so AR has to wait
        for (int i = 0; i < `RESP_DEPTH + 2; i++) begin
            add_entry("stall_credit", OP_READ, 32'h100 + 4 * i, RR_STALL, RESP_OKAY);
        end
        add_entry("decerr_mix", OP_READ, 32'h010, RR_ALWAYS, RESP_OKAY);
        add_entry("decerr_mix", OP_READ, 32'h400, RR_ALWAYS, RESP_DECERR);
        add_entry("decerr_mix", OP_READ, 32'h014, RR_ALWAYS, RESP_OKAY);
        add_entry("decerr_mix", OP_READ, 32'hffff_fffc, RR_ALWAYS, RESP_DECERR);
        add_entry("decerr_mix", OP_READ, 32'h018, RR_ALWAYS, RESP_OKAY);
        add_entry("write_slverr", OP_WRITE, 32'h020, RR_ALWAYS, RESP_SLVERR);
        add_entry("write_readback", OP_READ, 32'h020, RR_ALWAYS, RESP_OKAY);
        for (int i = 0; i < 24; i++) begin
            add_entry("random_sweep", OP_READ, 32'h200 + 4 * i, RR_RANDOM, RESP_OKAY);
        end
    endtask

    // all slots should be taken when the stall ends
    task automatic check_stall();
        if (open_count != `RESP_DEPTH) begin
            $display("[ERROR] %s reads in flight expected %0d actual %0d",
                     cur_name, `RESP_DEPTH, open_count);
            tb_errors++;
        end
        if (arready) begin
            $display("arready was still high with every response slot in use");
            tb_errors++;
        end
    endtask

    // one clock, then drive rready for the current pattern
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (stall_left > 0) begin
            stall_left--;
            if (stall_left == 0) begin
                check_stall();
            end
        end
        case (rr_mode)
            RR_RANDOM: rready = ($urandom % 4) != 0;
            RR_STALL:  rready = (stall_left == 0);
            default:   rready = 1'b1;
        endcase
    endtask

    task automatic drain();
        while (open_count != 0 || bvalid) begin
            next_cycle();
        end
    endtask

    task automatic issue_read(input logic [31:0] addr);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            next_cycle();
            #1;
        end
        next_cycle();
        arvalid = 1'b0;
    endtask

    task automatic issue_write(input logic [31:0] addr);
        awaddr  = addr;
        wdata   = {addr[15:0], 16'h5a5a};
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!awready) begin
            next_cycle();
            #1;
        end
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h2f42_8f17));
        rst_n   = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        build_table();
        cycle_limit = 40 * n_entries + 200;
        repeat (16) @(posedge clk);
        #1;
        rst_n  = 1'b1;
        rready = 1'b1;
        bready = 1'b1;
        for (int e = 0; e < n_entries; e++) begin
            // each test finishes before the next one starts
            if (t_name[e] != cur_name) begin
                drain();
                cur_name = t_name[e];
                rr_mode  = t_rr[e];
                if (rr_mode == RR_STALL) begin
                    stall_left = STALL_CYCLES;
                    rready     = 1'b0;
                end
            end
            chk0.note_entry(t_name[e], t_resp[e]);
            if (t_op[e] == OP_WRITE) begin
                issue_write(t_addr[e]);
            end else begin
                issue_read(t_addr[e]);
            end
        end
        drain();
        $display("errors: %0d response mismatches, %0d other", mismatches, tb_errors);
        if (mismatches == 0 && tb_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+hw
hw/rom_parity_pkg.sv
hw/rom_parity.sv
hw/axil_read_dispatch.sv
hw/resp_collector.sv
hw/parity_rom_top.sv
verif/rom_checker.sv
verif/tb_parity_rom.sv

/* Makefile */
TOP := tb_parity_rom

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
